// File: common/switch_pkg.sv
package switch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // default sizes of the switch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int NUM_PORTS_DEF  = 4;    // inputs and outputs.
    localparam int DATA_W_DEF     = 16;   // bits per packet word.
    localparam int FIFO_DEPTH_DEF = 8;    // words per ingress FIFO.
    localparam int SLOT_LEN_DEF   = 2;    // cycles per slot.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ingress FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // wait_grant and send together form the vld level seen by the arbiter.
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        SEND,
        GAP
    } port_state_e;

endpackage

// File: hdl/slot_timer.sv
`timescale 1ns/1ps

module slot_timer import switch_pkg::*; #(
    parameter int   NUM_PORTS = NUM_PORTS_DEF,
    parameter int   SLOT_LEN  = SLOT_LEN_DEF,
    localparam int  SEL_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic [SEL_W-1:0]    slot
);

    localparam int PRE_W = (SLOT_LEN > 1) ? $clog2(SLOT_LEN) : 1;

    logic [PRE_W-1:0] pre_cnt;

    // the prescaler holds each slot value for SLOT_LEN cycles.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            slot    <= '0;
        end else if (pre_cnt == PRE_W'(SLOT_LEN - 1)) begin
            pre_cnt <= '0;
            if (slot == SEL_W'(NUM_PORTS - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // tags in ready_generate are compared against this value, so it must stay in range.
    a_slot_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(slot) < NUM_PORTS
    );

endmodule

// File: hdl/ready_generate.sv
`timescale 1ns/1ps

module ready_generate import switch_pkg::*; #(
    parameter int   NUM_PORTS = NUM_PORTS_DEF,
    localparam int  SEL_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [SEL_W-1:0]            slot,
    input  logic [NUM_PORTS-1:0]        vld,
    input  logic [NUM_PORTS*SEL_W-1:0]  dest,
    output logic [NUM_PORTS-1:0]        ready
);

    logic [SEL_W-1:0]       slot_q;
    logic [NUM_PORTS-1:0]   vld_q;
    logic [NUM_PORTS-1:0]   vld_fall;
    logic [SEL_W-1:0]       dest_a [NUM_PORTS];
    logic [SEL_W-1:0]       tag [NUM_PORTS];      // one slot tag per output.
    logic [NUM_PORTS-1:0]   busy;                 // output is owned by an input.
    logic [NUM_PORTS-1:0]   grant_d;
    logic [NUM_PORTS-1:0]   take_d;
    logic [NUM_PORTS-1:0]   free_d;

    assign vld_fall = vld_q & ~vld;   // end of packet on that input.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arbitration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        logic found;
        found   = 1'b0;
        grant_d = '0;
        take_d  = '0;
        free_d  = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            dest_a[i] = dest[i*SEL_W +: SEL_W];
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (vld_fall[i]) begin
                free_d[dest_a[i]] = 1'b1;
            end
        end
        // each output picks the lowest waiting input while its tag matches the slot.
        for (int j = 0; j < NUM_PORTS; j++) begin
            found = 1'b0;
            if (!busy[j] && tag[j] == slot) begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (!found && vld[i] && dest_a[i] == SEL_W'(j)) begin
                        found      = 1'b1;
                        grant_d[i] = 1'b1;
                        take_d[j]  = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
            vld_q  <= '0;
            busy   <= '0;
            ready  <= '0;
            for (int j = 0; j < NUM_PORTS; j++) begin
                tag[j] <= SEL_W'((j + 1) % NUM_PORTS);
            end
        end else begin
            slot_q <= slot;
            vld_q  <= vld;
            ready  <= grant_d;
            busy   <= (busy & ~free_d) | take_d;
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (free_d[j]) begin
                    tag[j] <= slot_q;   // the slot of the cycle before the fall.
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_chk
        logic [NUM_PORTS-1:0] ready_to_out;

        always_comb begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                ready_to_out[i] = ready[i] && dest_a[i] == SEL_W'(j);
            end
        end

        a_one_grant: assert property (
            @(posedge clk) disable iff (!rst_n)
            $onehot0(ready_to_out)
        );
    end

    // the grant is registered, so the input must still be waiting one cycle later.
    a_grant_vld: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ready & ~vld) == '0
    );

endmodule

// File: ingress/ingress_fifo.sv
`timescale 1ns/1ps

module ingress_fifo import switch_pkg::*; #(
    parameter int   NUM_PORTS  = NUM_PORTS_DEF,
    parameter int   DATA_W     = DATA_W_DEF,
    parameter int   FIFO_DEPTH = FIFO_DEPTH_DEF,
    localparam int  SEL_W      = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic [DATA_W-1:0]   wr_data,
    input  logic                wr_last,
    input  logic [SEL_W-1:0]    wr_dest,
    output logic                full,
    input  logic                rd_en,
    output logic [DATA_W-1:0]   rd_data,
    output logic                rd_last,
    output logic [SEL_W-1:0]    rd_dest,
    output logic                pkt_avail
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0]  mem_data [FIFO_DEPTH];
    logic               mem_last [FIFO_DEPTH];
    logic [SEL_W-1:0]   mem_dest [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   pkt_cnt;    // complete packets held.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= wr_data;
            mem_last[wr_ptr] <= wr_last;
            mem_dest[wr_ptr] <= wr_dest;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            pkt_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
            pkt_cnt <= pkt_cnt + CNT_W'(wr_en && wr_last) - CNT_W'(rd_en && rd_last);
        end
    end

    // head word is shown ahead so the port can stream one word per cycle.
    assign rd_data   = mem_data[rd_ptr];
    assign rd_last   = mem_last[rd_ptr];
    assign rd_dest   = mem_dest[rd_ptr];
    assign full      = count == CNT_W'(FIFO_DEPTH);
    assign pkt_avail = pkt_cnt != '0;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> count != '0);

endmodule

// File: ingress/ingress_port.sv
`timescale 1ns/1ps

module ingress_port import switch_pkg::*; #(
    parameter int   NUM_PORTS  = NUM_PORTS_DEF,
    parameter int   DATA_W     = DATA_W_DEF,
    parameter int   FIFO_DEPTH = FIFO_DEPTH_DEF,
    localparam int  SEL_W      = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [DATA_W-1:0]   in_data,
    input  logic [SEL_W-1:0]    in_dest,
    input  logic                in_last,
    output logic                in_ready,
    output logic                vld,
    output logic [SEL_W-1:0]    dest,
    input  logic                ready,
    output logic                tx_valid,
    output logic [DATA_W-1:0]   tx_data,
    output logic                tx_last
);

    port_state_e        state;
    port_state_e        state_nxt;
    logic               full;
    logic               wr_en;
    logic               mid_pkt;    // a packet has started but not ended.
    logic [SEL_W-1:0]   pkt_dest;
    logic [SEL_W-1:0]   wr_dest;
    logic               rd_en;
    logic [DATA_W-1:0]  rd_data;
    logic               rd_last;
    logic [SEL_W-1:0]   rd_dest;
    logic               pkt_avail;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_ready = !full;
    assign wr_en    = in_valid && !full;
    assign wr_dest  = mid_pkt ? pkt_dest : in_dest;   // only the first word names the output.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_pkt <= 1'b0;
        end else if (wr_en) begin
            mid_pkt <= !in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !mid_pkt) begin
            pkt_dest <= in_dest;
        end
    end

    ingress_fifo #(
        .NUM_PORTS  (NUM_PORTS),
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ingress_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_data    (in_data),
        .wr_last    (in_last),
        .wr_dest    (wr_dest),
        .full       (full),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rd_last    (rd_last),
        .rd_dest    (rd_dest),
        .pkt_avail  (pkt_avail)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (pkt_avail) state_nxt = WAIT_GRANT;
            WAIT_GRANT: if (ready) state_nxt = SEND;
            SEND:       if (rd_last) state_nxt = GAP;
            GAP:        state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            dest  <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && pkt_avail) begin
                dest <= rd_dest;    // held through gap so the arbiter can free the output.
            end
        end
    end

    assign vld      = (state == WAIT_GRANT) || (state == SEND);
    assign rd_en    = state == SEND;
    assign tx_valid = state == SEND;
    assign tx_data  = rd_data;
    assign tx_last  = rd_last;

endmodule

// File: hdl/egress_crossbar.sv
`timescale 1ns/1ps

module egress_crossbar import switch_pkg::*; #(
    parameter int   NUM_PORTS = NUM_PORTS_DEF,
    parameter int   DATA_W    = DATA_W_DEF,
    localparam int  SEL_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [NUM_PORTS-1:0]            ready,
    input  logic [NUM_PORTS*SEL_W-1:0]      dest,
    input  logic [NUM_PORTS-1:0]            tx_valid,
    input  logic [NUM_PORTS*DATA_W-1:0]     tx_data,
    input  logic [NUM_PORTS-1:0]            tx_last,
    output logic [NUM_PORTS-1:0]            out_valid,
    output logic [NUM_PORTS*DATA_W-1:0]     out_data,
    output logic [NUM_PORTS-1:0]            out_last,
    output logic [NUM_PORTS*SEL_W-1:0]      out_src
);

    logic [SEL_W-1:0]       dest_a [NUM_PORTS];
    logic [SEL_W-1:0]       src [NUM_PORTS];      // selected input per output.
    logic [NUM_PORTS-1:0]   act;                  // a packet is in flight on the output.
    logic [NUM_PORTS-1:0]   fwd;
    logic [NUM_PORTS-1:0]   fwd_last;
    logic [NUM_PORTS-1:0]   mapped;

    always_comb begin
        mapped = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            dest_a[i] = dest[i*SEL_W +: SEL_W];
        end
        for (int j = 0; j < NUM_PORTS; j++) begin
            fwd[j]      = act[j] && tx_valid[src[j]];
            fwd_last[j] = fwd[j] && tx_last[src[j]];
            if (act[j]) begin
                mapped[src[j]] = 1'b1;
            end
        end
    end

    // a grant opens the mapping, the forwarded last word closes it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act <= '0;
            for (int j = 0; j < NUM_PORTS; j++) begin
                src[j] <= '0;
            end
        end else begin
            act <= act & ~fwd_last;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (ready[i]) begin
                    act[dest_a[i]] <= 1'b1;
                    src[dest_a[i]] <= SEL_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
            out_last  <= '0;
        end else begin
            out_valid <= fwd;
            out_last  <= fwd_last;
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_PORTS; j++) begin
            out_data[j*DATA_W +: DATA_W] <= tx_data[src[j]*DATA_W +: DATA_W];
            out_src[j*SEL_W +: SEL_W]    <= src[j];
        end
    end

    // a sending input must have been granted an output one cycle earlier.
    a_tx_mapped: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_valid & ~mapped) == '0
    );

endmodule

// File: hdl/slot_switch_top.sv
`timescale 1ns/1ps

module slot_switch_top import switch_pkg::*; #(
    parameter int   NUM_PORTS  = NUM_PORTS_DEF,
    parameter int   DATA_W     = DATA_W_DEF,
    parameter int   FIFO_DEPTH = FIFO_DEPTH_DEF,
    parameter int   SLOT_LEN   = SLOT_LEN_DEF,
    localparam int  SEL_W      = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [NUM_PORTS-1:0]            in_valid,
    input  logic [NUM_PORTS*DATA_W-1:0]     in_data,
    input  logic [NUM_PORTS*SEL_W-1:0]      in_dest,
    input  logic [NUM_PORTS-1:0]            in_last,
    output logic [NUM_PORTS-1:0]            in_ready,
    output logic [NUM_PORTS-1:0]            out_valid,
    output logic [NUM_PORTS*DATA_W-1:0]     out_data,
    output logic [NUM_PORTS-1:0]            out_last,
    output logic [NUM_PORTS*SEL_W-1:0]      out_src
);

    logic [SEL_W-1:0]           slot;
    logic [NUM_PORTS-1:0]       vld;
    logic [NUM_PORTS*SEL_W-1:0] dest;
    logic [NUM_PORTS-1:0]       ready;
    logic [NUM_PORTS-1:0]       tx_valid;
    logic [NUM_PORTS*DATA_W-1:0] tx_data;
    logic [NUM_PORTS-1:0]       tx_last;

    slot_timer #(
        .NUM_PORTS  (NUM_PORTS),
        .SLOT_LEN   (SLOT_LEN)
    ) u_slot_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot       (slot)
    );

    ready_generate #(
        .NUM_PORTS  (NUM_PORTS)
    ) u_ready_generate (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot       (slot),
        .vld        (vld),
        .dest       (dest),
        .ready      (ready)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ingress
        ingress_port #(
            .NUM_PORTS  (NUM_PORTS),
            .DATA_W     (DATA_W),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_ingress_port (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_valid   (in_valid[i]),
            .in_data    (in_data[i*DATA_W +: DATA_W]),
            .in_dest    (in_dest[i*SEL_W +: SEL_W]),
            .in_last    (in_last[i]),
            .in_ready   (in_ready[i]),
            .vld        (vld[i]),
            .dest       (dest[i*SEL_W +: SEL_W]),
            .ready      (ready[i]),
            .tx_valid   (tx_valid[i]),
            .tx_data    (tx_data[i*DATA_W +: DATA_W]),
            .tx_last    (tx_last[i])
        );
    end

    egress_crossbar #(
        .NUM_PORTS  (NUM_PORTS),
        .DATA_W     (DATA_W)
    ) u_egress_crossbar (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .dest       (dest),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_last    (tx_last),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_src    (out_src)
    );

endmodule

// File: sim/tb_slot_switch.sv
`timescale 1ns/1ps

module tb_slot_switch
    import switch_pkg::*;
();

    localparam int NUM_PORTS   = NUM_PORTS_DEF;
    localparam int DATA_W      = DATA_W_DEF;
    localparam int FIFO_DEPTH  = FIFO_DEPTH_DEF;
    localparam int SLOT_LEN    = SLOT_LEN_DEF;
    localparam int SEL_W       = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int DRIVE_LIMIT = 4000;
    localparam int DRAIN_LIMIT = 2000;

    logic                           clk;
    logic                           rst_n;
    logic [NUM_PORTS-1:0]           in_valid;
    logic [NUM_PORTS*DATA_W-1:0]    in_data;
    logic [NUM_PORTS*SEL_W-1:0]     in_dest;
    logic [NUM_PORTS-1:0]           in_last;
    logic [NUM_PORTS-1:0]           in_ready;
    logic [NUM_PORTS-1:0]           out_valid;
    logic [NUM_PORTS*DATA_W-1:0]    out_data;
    logic [NUM_PORTS-1:0]           out_last;
    logic [NUM_PORTS*SEL_W-1:0]     out_src;

    logic [DATA_W:0]    exp_q [NUM_PORTS*NUM_PORTS][$];    // {last, data}, indexed src*N+dest.
    logic [31:0]        rng_state;
    int                 errors;
    int                 timeouts;
    int                 words_sent;
    int                 words_seen;
    logic               saw_stall;

    slot_switch_top #(
        .NUM_PORTS  (NUM_PORTS),
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .SLOT_LEN   (SLOT_LEN)
    ) u_slot_switch_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_dest    (in_dest),
        .in_last    (in_last),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_src    (out_src)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int k = 0; k < NUM_PORTS*NUM_PORTS; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_packets(input int pkts, input bit no_gaps, input bit one_dest);
        int                 pkts_left [NUM_PORTS];
        int                 words_left [NUM_PORTS];
        int                 pkt_len [NUM_PORTS];
        int                 gap [NUM_PORTS];
        logic [SEL_W-1:0]   pkt_dest [NUM_PORTS];
        logic [NUM_PORTS-1:0] taken;
        int                 cycles;
        bit                 busy;
        taken  = '0;
        cycles = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            pkts_left[i]  = pkts;
            words_left[i] = 0;
            pkt_len[i]    = 0;
            gap[i]        = 0;
            pkt_dest[i]   = '0;
        end
        do begin
            @(negedge clk);
            cycles++;
            busy = 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                // the word offered last cycle went in at the rising edge.
                if (taken[i]) begin
                    exp_q[i*NUM_PORTS + int'(pkt_dest[i])].push_back(
                        {in_last[i], in_data[i*DATA_W +: DATA_W]});
                    words_sent++;
                    words_left[i]--;
                    if (words_left[i] == 0) begin
                        pkts_left[i]--;
                        gap[i] = no_gaps ? 0 : int'(next_rand() % 4);
                    end
                end
                if (words_left[i] == 0 && pkts_left[i] > 0) begin
                    if (gap[i] > 0) begin
                        gap[i]--;
                    end else begin
                        words_left[i] = 1 + int'(next_rand() % 4);
                        pkt_len[i]    = words_left[i];
                        pkt_dest[i]   = one_dest ? SEL_W'(0) : SEL_W'(next_rand() % NUM_PORTS);
                    end
                end
                if (words_left[i] > 0) begin
                    if (taken[i] || !in_valid[i]) begin
                        in_data[i*DATA_W +: DATA_W] = DATA_W'(next_rand());
                        // words after the first carry a random destination to be ignored.
                        if (words_left[i] == pkt_len[i]) begin
                            in_dest[i*SEL_W +: SEL_W] = pkt_dest[i];
                        end else begin
                            in_dest[i*SEL_W +: SEL_W] = SEL_W'(next_rand() % NUM_PORTS);
                        end
                    end
                    in_valid[i] = 1'b1;
                    in_last[i]  = words_left[i] == 1;
                end else begin
                    in_valid[i] = 1'b0;
                    in_last[i]  = 1'b0;
                end
                if (in_valid[i] && !in_ready[i]) begin
                    saw_stall = 1'b1;
                end
                taken[i] = in_valid[i] && in_ready[i];   // in_ready holds until the next edge.
                busy     = busy || pkts_left[i] > 0;
            end
        end while (busy && cycles < DRIVE_LIMIT);
        in_valid = '0;
        in_last  = '0;
        if (busy) begin
            $display("timeout: the inputs did not accept all packets of a phase");
            timeouts++;
        end
    endtask

    task automatic wait_drained(input string phase);
        int cycles;
        cycles = 0;
        while (pending_words() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pending_words() != 0) begin
            $display("timeout: %0d words of the %s traffic never left the switch",
                     pending_words(), phase);
            timeouts++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin : out_monitor
        logic [SEL_W-1:0]   src;
        logic [DATA_W:0]    exp_word;
        int                 idx;
        if (rst_n) begin
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (out_valid[j]) begin
                    src = out_src[j*SEL_W +: SEL_W];
                    idx = int'(src)*NUM_PORTS + j;
                    words_seen++;
                    a_src: assert (exp_q[idx].size() != 0) else begin
                        $display("output %0d delivered a word from input %0d not sent there",
                                 j, src);
                        errors++;
                    end
                    if (exp_q[idx].size() != 0) begin
                        exp_word = exp_q[idx].pop_front();
                        a_data: assert (out_data[j*DATA_W +: DATA_W] == exp_word[DATA_W-1:0])
                        else begin
                            $display("[FAIL] out_data[%0d]: got %h expected %h", j,
                                     out_data[j*DATA_W +: DATA_W], exp_word[DATA_W-1:0]);
                            errors++;
                        end
                        a_last: assert (out_last[j] == exp_word[DATA_W]) else begin
                            $display("[FAIL] out_last[%0d]: got %h expected %h", j,
                                     out_last[j], exp_word[DATA_W]);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    a_reset_quiet: assert property (
        @(posedge clk) (!rst_n || $rose(rst_n)) |-> (out_valid == '0 && in_ready == '1)
    ) else begin
        $display("[FAIL] reset: out_valid %h in_ready %h", $sampled(out_valid),
                 $sampled(in_ready));
        errors++;
    end

    // a packet leaves in back to back cycles from a single source.
    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_pkt_chk
        a_no_break: assert property (
            @(posedge clk) disable iff (!rst_n)
            (out_valid[j] && !out_last[j]) |=>
                (out_valid[j] && out_src[j*SEL_W +: SEL_W] == $past(out_src[j*SEL_W +: SEL_W]))
        ) else begin
            $display("[FAIL] out_valid[%0d] %h out_src[%0d] %h inside a packet", j,
                     $sampled(out_valid[j]), j, $sampled(out_src[j*SEL_W +: SEL_W]));
            errors++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        errors     = 0;
        timeouts   = 0;
        words_sent = 0;
        words_seen = 0;
        saw_stall  = 1'b0;
        rng_state  = 32'd95;
        rst_n      = 1'b0;
        in_valid   = '0;
        in_data    = '0;
        in_dest    = '0;
        in_last    = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        drive_packets(12, 1'b0, 1'b0);    // mixed traffic with idle gaps.
        wait_drained("mixed");
        if (timeouts == 0) begin
            saw_stall = 1'b0;
            drive_packets(10, 1'b1, 1'b0);
            a_stall: assert (saw_stall) else begin
                $display("in_ready never dropped during the burst traffic");
                errors++;
            end
            wait_drained("burst");
        end
        // every input targets output 0, so all packets wait on the same output tag.
        if (timeouts == 0) begin
            drive_packets(6, 1'b1, 1'b1);
            wait_drained("single output");
        end
        repeat (20) @(posedge clk);

        for (int k = 0; k < NUM_PORTS*NUM_PORTS; k++) begin
            a_empty: assert (exp_q[k].size() == 0) else begin
                $display("%0d words from input %0d to output %0d were never delivered",
                         exp_q[k].size(), k / NUM_PORTS, k % NUM_PORTS);
                errors++;
            end
        end
        a_count: assert (words_sent == words_seen) else begin
            $display("[FAIL] word count: sent %h received %h", words_sent, words_seen);
            errors++;
        end

        $display("errors %0d, timeouts %0d, words sent %0d, words received %0d",
                 errors, timeouts, words_sent, words_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
common/switch_pkg.sv
hdl/slot_timer.sv
hdl/ready_generate.sv
ingress/ingress_fifo.sv
ingress/ingress_port.sv
hdl/egress_crossbar.sv
hdl/slot_switch_top.sv
sim/tb_slot_switch.sv

// File: Bender.yml
package:
  name: slot_switch

sources:
  - common/switch_pkg.sv
  - hdl/slot_timer.sv
  - hdl/ready_generate.sv
  - ingress/ingress_fifo.sv
  - ingress/ingress_port.sv
  - hdl/egress_crossbar.sv
  - hdl/slot_switch_top.sv
  - target: simulation
    files:
      - sim/tb_slot_switch.sv
